// File: source/mem_slot_defs.svh
// Memory slot build constants
// Bus widths, request tag width and the bus timeout and retry limits
// for the load/store data-memory slot

`ifndef MEM_SLOT_DEFS_SVH
`define MEM_SLOT_DEFS_SVH

// ======================================================================
// Bus geometry
// ======================================================================
`define MEM_ADR_W 32
`define MEM_DAT_W 64
`define MEM_SEL_W 8
// Byte offset within one bus word
`define MEM_OFS_W 3
`define MEM_TAG_W 6

// ======================================================================
// Bus timeout and retry
// ======================================================================
// Cycles a beat may wait for an acknowledge before it is retried
`define BUS_TO_CYCLES 16
`define BUS_TO_CNT_W 5
// Retries of an access before a bus fault is reported
`define BUS_RETRIES 2
`define BUS_RTY_CNT_W 2

`endif

// File: source/mem_op_pkg.sv
// Memory opcode package
// Describes the instruction side of the slot with the opcode encoding
// and the access size, direction and extension rules of each opcode

`default_nettype none

package mem_op_pkg;

	// Loads come first and stores last in the encoding
	typedef enum logic [3:0] {
		LB  = 4'h0,
		LBU = 4'h1,
		LH  = 4'h2,
		LHU = 4'h3,
		LW  = 4'h4,
		LWU = 4'h5,
		LD  = 4'h6,
		SB  = 4'h8,
		SH  = 4'h9,
		SW  = 4'hA,
		SD  = 4'hB
	} mem_op_e;

	// Number of bytes moved by an opcode
	function automatic logic [3:0] op_size(mem_op_e op);
		case (op)
			LB, LBU, SB: op_size = 4'd1;
			LH, LHU, SH: op_size = 4'd2;
			LW, LWU, SW: op_size = 4'd4;
			default:     op_size = 4'd8;
		endcase
	endfunction

	// True for opcodes that write memory
	function automatic logic op_is_store(mem_op_e op);
		return op inside {SB, SH, SW, SD};
	endfunction

	// True for loads that copy the top bit of the loaded value upward
	function automatic logic op_signed(mem_op_e op);
		return op inside {LB, LH, LW};
	endfunction

endpackage

`default_nettype wire

// File: source/mem_slot_pkg.sv
// Memory slot package
// Describes the slot side with the sequencing states and the fault code
// that goes back with every completion

`default_nettype none

package mem_slot_pkg;

	// Sequencing of one access through the slot
	typedef enum logic [2:0] {
		SLOT_IDLE  = 3'd0,
		SLOT_LO    = 3'd1,
		SLOT_HI    = 3'd2,
		SLOT_RETRY = 3'd3,
		SLOT_DONE  = 3'd4
	} slot_state_e;

	// Fault reported with a result
	typedef enum logic {
		FLT_NONE = 1'b0,
		FLT_BUS  = 1'b1
	} mem_fault_e;

	// A beat is on the bus only in the two beat states
	function automatic logic slot_on_bus(slot_state_e st);
		return st == SLOT_LO || st == SLOT_HI;
	endfunction

endpackage

`default_nettype wire

// File: source/mem_slot_if.sv
// Memory slot control interface
// Carries the strobes between the sequencer, the bus timer and the
// work register of the slot

`timescale 1ns/1ps
`default_nettype none

interface mem_slot_if;

	// Strobes from the sequencer to the work register
	logic capture;
	logic beat_hi;
	logic take_lo;
	logic take_hi;
	logic finish;
	logic fault;
	// Timer control
	logic count_en;
	logic count_clr;
	// Access crosses an 8-byte boundary
	logic split;
	// One-cycle timeout pulse
	logic expire;

	modport fsm (output capture, beat_hi, take_lo, take_hi, finish, fault,
		count_en, count_clr, input split, expire);
	modport timer (input count_en, count_clr, output expire);
	modport work (input capture, beat_hi, take_lo, take_hi, finish, fault,
		output split);

endinterface

`default_nettype wire

// File: source/bus_timeout_timer.sv
// Bus timeout timer
// Counts cycles that a beat waits for its acknowledge and pulses expire
// once when the limit is reached

`timescale 1ns/1ps
`default_nettype none
`include "mem_slot_defs.svh"

module bus_timeout_timer (
	input wire clk_i,
	input wire rst_i,
	mem_slot_if.timer slot
);

	logic [`BUS_TO_CNT_W-1:0] cnt_q;
	logic at_limit;

	// Counter has saturated and waits for the next clear
	assign at_limit = cnt_q == `BUS_TO_CNT_W'(`BUS_TO_CYCLES);

	// The pulse lands in the last counted cycle so that it comes exactly
	// BUS_TO_CYCLES cycles after the clear
	assign slot.expire = slot.count_en & ~slot.count_clr &
		(cnt_q == `BUS_TO_CNT_W'(`BUS_TO_CYCLES - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i)
			cnt_q <= '0;
		else if (slot.count_clr)
			cnt_q <= '0;
		else if (slot.count_en && !at_limit)
			cnt_q <= cnt_q + 1'b1;
	end

	// Saturation keeps a stalled beat from timing out again
	assert property (@(posedge clk_i) disable iff (rst_i)
		slot.expire |=> !slot.expire);

endmodule

`default_nettype wire

// File: source/mem_slot_fsm.sv
// Memory slot sequencer
// Walks an access through its low and high beats, retries a beat that
// times out and raises the finish strobe for the completion

`timescale 1ns/1ps
`default_nettype none
`include "mem_slot_defs.svh"

module mem_slot_fsm (
	input  wire  clk_i,
	input  wire  rst_i,
	input  wire  req_v_i,
	input  wire  bus_ack_i,
	output logic req_rdy_o,
	output logic bus_req_o,
	mem_slot_if.fsm slot
);

	mem_slot_pkg::slot_state_e state_q;
	mem_slot_pkg::slot_state_e state_d;
	// Remembers which beat a retry returns to
	logic hi_q;
	logic [`BUS_RTY_CNT_W-1:0] rty_q;
	logic timed_out;
	logic give_up;

	// ======================================================================
	// Strobes decoded from the state
	// ======================================================================
	assign req_rdy_o = state_q == mem_slot_pkg::SLOT_IDLE;
	assign bus_req_o = mem_slot_pkg::slot_on_bus(state_q);
	assign slot.capture = req_rdy_o & req_v_i;
	assign slot.beat_hi = hi_q;
	assign slot.take_lo = state_q == mem_slot_pkg::SLOT_LO && bus_ack_i;
	assign slot.take_hi = state_q == mem_slot_pkg::SLOT_HI && bus_ack_i;
	// An acknowledge in the same cycle wins over the timer
	assign timed_out = bus_req_o & ~bus_ack_i & slot.expire;
	assign give_up = timed_out && rty_q == `BUS_RTY_CNT_W'(`BUS_RETRIES);
	assign slot.finish = (slot.take_lo & ~slot.split) | slot.take_hi | give_up;
	assign slot.fault = give_up;
	assign slot.count_en = bus_req_o;
	// The timer restarts for every fresh beat and after each retry gap
	assign slot.count_clr = slot.capture | (slot.take_lo & slot.split) |
		(state_q == mem_slot_pkg::SLOT_RETRY);

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_slot_pkg::SLOT_IDLE:
				if (slot.capture)
					state_d = mem_slot_pkg::SLOT_LO;
			mem_slot_pkg::SLOT_LO, mem_slot_pkg::SLOT_HI:
				if (slot.take_lo && slot.split)
					state_d = mem_slot_pkg::SLOT_HI;
				else if (slot.finish)
					state_d = mem_slot_pkg::SLOT_DONE;
				else if (timed_out)
					state_d = mem_slot_pkg::SLOT_RETRY;
			// Bus request stays low here for a single cycle
			mem_slot_pkg::SLOT_RETRY:
				state_d = hi_q ? mem_slot_pkg::SLOT_HI : mem_slot_pkg::SLOT_LO;
			default:
				state_d = mem_slot_pkg::SLOT_IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= mem_slot_pkg::SLOT_IDLE;
			hi_q <= 1'b0;
			rty_q <= '0;
		end else begin
			state_q <= state_d;
			if (slot.capture) begin
				hi_q <= 1'b0;
				rty_q <= '0;
			end else begin
				if (slot.take_lo && slot.split)
					hi_q <= 1'b1;
				// Retries are counted over the whole access, not per beat
				if (timed_out && !give_up)
					rty_q <= rty_q + 1'b1;
			end
		end
	end

	// The bus request is only withdrawn by an acknowledge or a timeout
	assert property (@(posedge clk_i) disable iff (rst_i)
		bus_req_o && !bus_ack_i && !slot.expire |=> bus_req_o);
	// One access yields exactly one completion strobe
	assert property (@(posedge clk_i) disable iff (rst_i)
		slot.finish |=> !slot.finish);

endmodule

`default_nettype wire

// File: source/mem_slot_work.sv
// Memory slot work register
// Holds the access in flight, forms the byte enables and store data of
// each bus beat and assembles, aligns and extends the load result

`timescale 1ns/1ps
`default_nettype none
`include "mem_slot_defs.svh"

module mem_slot_work (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  mem_op_pkg::mem_op_e        req_op_i,
	input  wire  [`MEM_ADR_W-1:0]      req_adr_i,
	input  wire  [`MEM_DAT_W-1:0]      req_dat_i,
	input  wire  [`MEM_TAG_W-1:0]      req_tag_i,
	input  wire                        kill_i,
	output logic                       bus_we_o,
	output logic [`MEM_ADR_W-1:0]      bus_adr_o,
	output logic [`MEM_SEL_W-1:0]      bus_sel_o,
	output logic [`MEM_DAT_W-1:0]      bus_dat_o,
	input  wire  [`MEM_DAT_W-1:0]      bus_dat_i,
	output logic                       res_v_o,
	output logic [`MEM_TAG_W-1:0]      res_tag_o,
	output logic [`MEM_DAT_W-1:0]      res_dat_o,
	output mem_slot_pkg::mem_fault_e   res_fault_o,
	mem_slot_if.work slot
);

	// Captured request
	mem_op_pkg::mem_op_e op_q;
	logic [`MEM_TAG_W-1:0] tag_q;
	logic [`MEM_ADR_W-1:0] adr_q;
	logic [`MEM_DAT_W-1:0] dat_q;
	// Low beat read data kept while the high beat runs
	logic [`MEM_DAT_W-1:0] lo_q;
	logic held_q;
	logic killed_q;

	logic [`MEM_OFS_W-1:0] ofs;
	logic [`MEM_OFS_W+2:0] lo_sh;
	logic [`MEM_OFS_W+3:0] hi_sh;
	logic [`MEM_SEL_W-1:0] size_mask;
	logic [2*`MEM_SEL_W-1:0] sel_wide;
	logic [2*`MEM_DAT_W-1:0] dat_wide;
	logic [`MEM_ADR_W-`MEM_OFS_W-1:0] word_adr;
	logic [`MEM_DAT_W-1:0] raw;

	// Sign or zero extension of the aligned load data by opcode
	function automatic logic [`MEM_DAT_W-1:0] extend_load(mem_op_pkg::mem_op_e op,
		logic [`MEM_DAT_W-1:0] d);
		logic sgn;
		sgn = mem_op_pkg::op_signed(op);
		case (mem_op_pkg::op_size(op))
			4'd1: extend_load = {{(`MEM_DAT_W-8){sgn & d[7]}}, d[7:0]};
			4'd2: extend_load = {{(`MEM_DAT_W-16){sgn & d[15]}}, d[15:0]};
			4'd4: extend_load = {{(`MEM_DAT_W-32){sgn & d[31]}}, d[31:0]};
			default: extend_load = d;
		endcase
	endfunction

	// ======================================================================
	// Beat formation
	// ======================================================================
	assign ofs = adr_q[`MEM_OFS_W-1:0];
	// Bit shift of the low part and the complementary shift of the high part
	assign lo_sh = {ofs, 3'b000};
	assign hi_sh = 7'(`MEM_DAT_W) - {1'b0, lo_sh};
	assign size_mask = {`MEM_SEL_W{1'b1}} >> (`MEM_SEL_W - mem_op_pkg::op_size(op_q));
	// Enables and data laid over two bus words, the upper word is the high beat
	assign sel_wide = {{`MEM_SEL_W{1'b0}}, size_mask} << ofs;
	assign dat_wide = {{`MEM_DAT_W{1'b0}}, dat_q} << lo_sh;
	assign word_adr = adr_q[`MEM_ADR_W-1:`MEM_OFS_W];
	assign slot.split = |sel_wide[2*`MEM_SEL_W-1:`MEM_SEL_W];

	assign bus_we_o = mem_op_pkg::op_is_store(op_q);
	assign bus_adr_o = slot.beat_hi ? {word_adr + 1'b1, {`MEM_OFS_W{1'b0}}} :
		{word_adr, {`MEM_OFS_W{1'b0}}};
	assign bus_sel_o = slot.beat_hi ? sel_wide[2*`MEM_SEL_W-1:`MEM_SEL_W] :
		sel_wide[`MEM_SEL_W-1:0];
	assign bus_dat_o = slot.beat_hi ? dat_wide[2*`MEM_DAT_W-1:`MEM_DAT_W] :
		dat_wide[`MEM_DAT_W-1:0];

	// ======================================================================
	// Result assembly
	// ======================================================================
	// A two-beat load joins the low beat shifted down with the high beat
	// shifted up, a single beat only needs the shift down
	assign raw = slot.take_hi ? (lo_q >> lo_sh) | (bus_dat_i << hi_sh) :
		bus_dat_i >> lo_sh;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			held_q <= 1'b0;
			killed_q <= 1'b0;
			res_v_o <= 1'b0;
		end else begin
			// Completion is dropped if a kill was seen at any point in flight
			res_v_o <= slot.finish & ~killed_q & ~kill_i;
			if (slot.capture) begin
				held_q <= 1'b1;
				killed_q <= 1'b0;
			end else if (slot.finish) begin
				held_q <= 1'b0;
			end else if (held_q && kill_i) begin
				killed_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (slot.capture) begin
			op_q <= req_op_i;
			tag_q <= req_tag_i;
			adr_q <= req_adr_i;
			dat_q <= req_dat_i;
		end
		if (slot.take_lo)
			lo_q <= bus_dat_i;
		if (slot.finish) begin
			res_tag_o <= tag_q;
			res_fault_o <= slot.fault ? mem_slot_pkg::FLT_BUS : mem_slot_pkg::FLT_NONE;
			// A fault or a store returns zero data
			if (slot.fault || mem_op_pkg::op_is_store(op_q))
				res_dat_o <= '0;
			else
				res_dat_o <= extend_load(op_q, raw);
		end
	end

	// The sequencer only captures once the previous access has finished
	assert property (@(posedge clk_i) disable iff (rst_i)
		slot.capture |-> !held_q);

endmodule

`default_nettype wire

// File: source/mem_slot_top.sv
// Memory slot top level
// Joins the sequencer, the bus timer and the work register of the
// load/store data-memory slot to the request, bus and result ports

`timescale 1ns/1ps
`default_nettype none
`include "mem_slot_defs.svh"

module mem_slot_top (
	input  wire                        clk_i,
	input  wire                        rst_i,
	// Request from the issue queue
	input  wire                        req_v_i,
	input  mem_op_pkg::mem_op_e        req_op_i,
	input  wire  [`MEM_ADR_W-1:0]      req_adr_i,
	input  wire  [`MEM_DAT_W-1:0]      req_dat_i,
	input  wire  [`MEM_TAG_W-1:0]      req_tag_i,
	output logic                       req_rdy_o,
	input  wire                        kill_i,
	// Memory bus
	output logic                       bus_req_o,
	output logic                       bus_we_o,
	output logic [`MEM_ADR_W-1:0]      bus_adr_o,
	output logic [`MEM_SEL_W-1:0]      bus_sel_o,
	output logic [`MEM_DAT_W-1:0]      bus_dat_o,
	input  wire                        bus_ack_i,
	input  wire  [`MEM_DAT_W-1:0]      bus_dat_i,
	// Completion
	output logic                       res_v_o,
	output logic [`MEM_TAG_W-1:0]      res_tag_o,
	output logic [`MEM_DAT_W-1:0]      res_dat_o,
	output mem_slot_pkg::mem_fault_e   res_fault_o
);

	mem_slot_if slot ();

	mem_slot_fsm i_fsm (
		.clk_i(clk_i), .rst_i(rst_i), .req_v_i(req_v_i), .bus_ack_i(bus_ack_i),
		.req_rdy_o(req_rdy_o), .bus_req_o(bus_req_o), .slot(slot.fsm)
	);

	bus_timeout_timer i_timer (.clk_i(clk_i), .rst_i(rst_i), .slot(slot.timer));

	mem_slot_work i_work (
		.clk_i(clk_i), .rst_i(rst_i), .req_op_i(req_op_i), .req_adr_i(req_adr_i),
		.req_dat_i(req_dat_i), .req_tag_i(req_tag_i), .kill_i(kill_i),
		.bus_we_o(bus_we_o), .bus_adr_o(bus_adr_o), .bus_sel_o(bus_sel_o),
		.bus_dat_o(bus_dat_o), .bus_dat_i(bus_dat_i), .res_v_o(res_v_o),
		.res_tag_o(res_tag_o), .res_dat_o(res_dat_o), .res_fault_o(res_fault_o),
		.slot(slot.work)
	);

endmodule

`default_nettype wire

// File: dv/mem_slot_tb.sv
// Memory slot testbench
// Directed tests of the load/store data-memory slot against a byte-wide
// reference memory, with a bus memory model of settable acknowledge delay

`timescale 1ns/1ps
`default_nettype none
`include "mem_slot_defs.svh"

module mem_slot_tb;

	// Worst case per access is every retry running to its timeout
	localparam int num_ops = 80;
	localparam int cycle_limit = num_ops * (`BUS_RETRIES + 1) * (`BUS_TO_CYCLES + 2) + 500;

	logic clk_i = 1'b0;
	logic rst_i;
	logic req_v_i;
	mem_op_pkg::mem_op_e req_op_i;
	logic [`MEM_ADR_W-1:0] req_adr_i;
	logic [`MEM_DAT_W-1:0] req_dat_i;
	logic [`MEM_TAG_W-1:0] req_tag_i;
	logic req_rdy_o;
	logic kill_i;
	logic bus_req_o;
	logic bus_we_o;
	logic [`MEM_ADR_W-1:0] bus_adr_o;
	logic [`MEM_SEL_W-1:0] bus_sel_o;
	logic [`MEM_DAT_W-1:0] bus_dat_o;
	logic bus_ack_i;
	logic [`MEM_DAT_W-1:0] bus_dat_i;
	logic res_v_o;
	logic [`MEM_TAG_W-1:0] res_tag_o;
	logic [`MEM_DAT_W-1:0] res_dat_o;
	mem_slot_pkg::mem_fault_e res_fault_o;

	// Bus memory seen by the DUT and the expected contents kept by the tests
	logic [7:0] bus_mem [0:255];
	logic [7:0] ref_mem [0:255];
	int ack_delay;
	bit silent;
	int wait_cnt;
	// Bus beat and completion monitor
	int beats;
	int beat_adr[$];
	int results;
	bit req_seen;
	bit ack_seen;
	// Last completion and bookkeeping
	logic [`MEM_DAT_W-1:0] got_dat;
	mem_slot_pkg::mem_fault_e got_flt;
	logic [`MEM_TAG_W-1:0] got_tag;
	logic [`MEM_TAG_W-1:0] tag;
	int checks;
	int errors;
	int tests;
	int cycles;
	integer seed;
	mem_op_pkg::mem_op_e all_ops [11];

	mem_slot_top i_dut (
		.clk_i(clk_i), .rst_i(rst_i), .req_v_i(req_v_i), .req_op_i(req_op_i),
		.req_adr_i(req_adr_i), .req_dat_i(req_dat_i), .req_tag_i(req_tag_i),
		.req_rdy_o(req_rdy_o), .kill_i(kill_i), .bus_req_o(bus_req_o),
		.bus_we_o(bus_we_o), .bus_adr_o(bus_adr_o), .bus_sel_o(bus_sel_o),
		.bus_dat_o(bus_dat_o), .bus_ack_i(bus_ack_i), .bus_dat_i(bus_dat_i),
		.res_v_o(res_v_o), .res_tag_o(res_tag_o), .res_dat_o(res_dat_o),
		.res_fault_o(res_fault_o)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	// ======================================================================
	// Bus memory model
	// ======================================================================
	// Acknowledges a beat after ack_delay waiting cycles unless silent
	always @(posedge clk_i) begin : mem_model
		logic [`MEM_DAT_W-1:0] rd;
		int base;
		base = 8 * int'(bus_adr_o[7:3]);
		for (int k = 0; k < 8; k++)
			rd[8*k +: 8] = bus_mem[base + k];
		bus_ack_i <= 1'b0;
		if (rst_i || !bus_req_o || bus_ack_i) begin
			wait_cnt <= 0;
		end else if (!silent && wait_cnt >= ack_delay) begin
			bus_ack_i <= 1'b1;
			wait_cnt <= 0;
			bus_dat_i <= rd;
			for (int k = 0; k < 8; k++)
				if (bus_we_o && bus_sel_o[k])
					bus_mem[base + k] <= bus_dat_o[8*k +: 8];
		end else begin
			wait_cnt <= wait_cnt + 1;
		end
	end

	// A beat starts when the request rises or stays up past an acknowledge
	always @(negedge clk_i) begin
		if (bus_req_o && (!req_seen || ack_seen)) begin
			beats++;
			beat_adr.push_back(int'(bus_adr_o));
		end
		if (res_v_o)
			results++;
		req_seen = bus_req_o;
		ack_seen = bus_ack_i;
	end

	// ======================================================================
	// Opcode rules and expected values
	// ======================================================================
	function automatic int byte_count(mem_op_pkg::mem_op_e op);
		case (op)
			mem_op_pkg::LB, mem_op_pkg::LBU, mem_op_pkg::SB: return 1;
			mem_op_pkg::LH, mem_op_pkg::LHU, mem_op_pkg::SH: return 2;
			mem_op_pkg::LW, mem_op_pkg::LWU, mem_op_pkg::SW: return 4;
			default: return 8;
		endcase
	endfunction

	function automatic bit is_store_op(mem_op_pkg::mem_op_e op);
		return op == mem_op_pkg::SB || op == mem_op_pkg::SH ||
			op == mem_op_pkg::SW || op == mem_op_pkg::SD;
	endfunction

	function automatic bit sign_extends(mem_op_pkg::mem_op_e op);
		return op == mem_op_pkg::LB || op == mem_op_pkg::LH || op == mem_op_pkg::LW;
	endfunction

	// Little-endian gather from the reference bytes, then extension
	function automatic logic [`MEM_DAT_W-1:0] expected_load(mem_op_pkg::mem_op_e op, int adr);
		logic [`MEM_DAT_W-1:0] v;
		int n;
		v = '0;
		n = byte_count(op);
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = ref_mem[adr + i];
		if (sign_extends(op) && v[8*n-1])
			for (int i = n; i < 8; i++)
				v[8*i +: 8] = 8'hff;
		return v;
	endfunction

	task automatic check_data(string name, logic [`MEM_DAT_W-1:0] exp, logic [`MEM_DAT_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: data expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_fault(string name, mem_slot_pkg::mem_fault_e exp,
		mem_slot_pkg::mem_fault_e act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: fault expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("mismatch %s: count expected %0d actual %0d", name, exp, act);
		end
	endtask

	// ======================================================================
	// Request and completion handling
	// ======================================================================
	// Waits for ready, then holds the request for the capture edge only
	task automatic send_request(mem_op_pkg::mem_op_e op, int adr, logic [`MEM_DAT_W-1:0] dat);
		do @(negedge clk_i); while (!req_rdy_o);
		@(posedge clk_i);
		tag = tag + 1'b1;
		req_v_i <= 1'b1;
		req_op_i <= op;
		req_adr_i <= 32'(adr);
		req_dat_i <= dat;
		req_tag_i <= tag;
		@(posedge clk_i);
		req_v_i <= 1'b0;
	endtask

	task automatic wait_result();
		do @(negedge clk_i); while (!res_v_o);
		got_dat = res_dat_o;
		got_flt = res_fault_o;
		got_tag = res_tag_o;
	endtask

	// One full access checked against the reference, stores update it
	task automatic run_access(string name, mem_op_pkg::mem_op_e op, int adr,
		logic [`MEM_DAT_W-1:0] dat);
		logic [`MEM_DAT_W-1:0] exp;
		exp = is_store_op(op) ? '0 : expected_load(op, adr);
		send_request(op, adr, dat);
		wait_result();
		check_data(name, exp, got_dat);
		check_fault(name, mem_slot_pkg::FLT_NONE, got_flt);
		check_count(name, int'(tag), int'(got_tag));
		if (is_store_op(op))
			for (int i = 0; i < byte_count(op); i++)
				ref_mem[adr + i] = dat[8*i +: 8];
	endtask

	task automatic finish_test(string name, int err0);
		tests++;
		if (errors == err0)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d errors", name, errors - err0);
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================
	// Loads in the first pass see a clear top bit and in the second pass a set one
	task automatic aligned_loads();
		int err0;
		int adr;
		int n;
		err0 = errors;
		ack_delay = 2;
		for (int p = 0; p < 2; p++)
			for (int k = 0; k < 7; k++) begin
				n = byte_count(all_ops[k]);
				adr = ((k * 37 + p * 101 + 3) % 248) & ~(n - 1);
				while (ref_mem[adr + n - 1][7] != p[0])
					adr = (adr + n) % 248;
				run_access("aligned_loads", all_ops[k], adr, '0);
			end
		finish_test("aligned_loads", err0);
	endtask

	// Each store lands in its own word, read back whole to see the neighbours
	task automatic aligned_stores();
		int err0;
		int adr;
		err0 = errors;
		ack_delay = 1;
		for (int k = 7; k < 11; k++) begin
			adr = 136 + 8 * (k - 7) + (8 - byte_count(all_ops[k]));
			run_access("aligned_stores", all_ops[k], adr, {$random(seed), $random(seed)});
			run_access("aligned_stores", mem_op_pkg::LD, adr & ~7, '0);
		end
		finish_test("aligned_stores", err0);
	endtask

	task automatic split_pair(mem_op_pkg::mem_op_e st, mem_op_pkg::mem_op_e ld, int adr);
		logic [`MEM_DAT_W-1:0] dat;
		int n;
		dat = {$random(seed), $random(seed)};
		n = byte_count(st);
		beats = 0;
		beat_adr.delete();
		run_access("split_access", st, adr, dat);
		check_count("split_access", 2, beats);
		if (beat_adr.size() == 2) begin
			check_count("split_access", adr & ~7, beat_adr[0]);
			check_count("split_access", (adr & ~7) + 8, beat_adr[1]);
		end
		run_access("split_access", ld, adr, '0);
		check_data("split_access", dat & ({`MEM_DAT_W{1'b1}} >> (64 - 8 * n)), got_dat);
	endtask

	task automatic split_access();
		int err0;
		err0 = errors;
		ack_delay = 3;
		split_pair(mem_op_pkg::SW, mem_op_pkg::LWU, 69);
		split_pair(mem_op_pkg::SD, mem_op_pkg::LD, 123);
		finish_test("split_access", err0);
	endtask

	task automatic silent_bus();
		int err0;
		err0 = errors;
		silent = 1'b1;
		beats = 0;
		send_request(mem_op_pkg::LD, 16, '0);
		wait_result();
		silent = 1'b0;
		check_count("silent_bus", 1 + `BUS_RETRIES, beats);
		check_data("silent_bus", '0, got_dat);
		check_fault("silent_bus", mem_slot_pkg::FLT_BUS, got_flt);
		run_access("silent_bus", mem_op_pkg::LD, 16, '0);
		finish_test("silent_bus", err0);
	endtask

	// A one-cycle kill while the load waits on the bus
	task automatic killed_load();
		int err0;
		int start;
		err0 = errors;
		ack_delay = 6;
		send_request(mem_op_pkg::LD, 40, '0);
		start = results;
		@(posedge clk_i);
		kill_i <= 1'b1;
		@(posedge clk_i);
		kill_i <= 1'b0;
		do @(negedge clk_i); while (!req_rdy_o);
		check_count("killed_load", 0, results - start);
		ack_delay = 1;
		run_access("killed_load", mem_op_pkg::LW, 44, '0);
		finish_test("killed_load", err0);
	endtask

	task automatic random_traffic();
		int err0;
		mem_op_pkg::mem_op_e op;
		int adr;
		err0 = errors;
		for (int k = 0; k < 40; k++) begin
			op = all_ops[$unsigned($random(seed)) % 11];
			adr = $unsigned($random(seed)) % 249;
			ack_delay = $unsigned($random(seed)) % 4;
			run_access("random_traffic", op, adr, {$random(seed), $random(seed)});
		end
		finish_test("random_traffic", err0);
	endtask

	initial begin
		rst_i <= 1'b1;
		req_v_i <= 1'b0;
		req_op_i <= mem_op_pkg::LB;
		req_adr_i <= '0;
		req_dat_i <= '0;
		req_tag_i <= '0;
		kill_i <= 1'b0;
		bus_ack_i <= 1'b0;
		bus_dat_i <= '0;
		seed = 18766;
		tag = '0;
		silent = 1'b0;
		ack_delay = 0;
		all_ops = '{mem_op_pkg::LB, mem_op_pkg::LBU, mem_op_pkg::LH, mem_op_pkg::LHU,
			mem_op_pkg::LW, mem_op_pkg::LWU, mem_op_pkg::LD, mem_op_pkg::SB,
			mem_op_pkg::SH, mem_op_pkg::SW, mem_op_pkg::SD};
		// Odd multiplier makes every byte address give its own value
		for (int a = 0; a < 256; a++) begin
			bus_mem[a] = 8'((a * 59) ^ 165);
			ref_mem[a] = 8'((a * 59) ^ 165);
		end
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
		aligned_loads();
		aligned_stores();
		split_access();
		silent_bus();
		killed_load();
		random_traffic();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/mem_op_pkg.sv
source/mem_slot_pkg.sv
source/mem_slot_if.sv
source/bus_timeout_timer.sv
source/mem_slot_fsm.sv
source/mem_slot_work.sv
source/mem_slot_top.sv
dv/mem_slot_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the memory slot testbench with Verilator, runs it and scans the log

set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module mem_slot_tb \
	-o mem_slot_sim

./obj_dir/mem_slot_sim > sim.log 2>&1 || {
	cat sim.log
	echo "simulation exited with an error"
	exit 1
}
cat sim.log

if grep -q -F '** FAIL **' sim.log; then
	exit 1
fi
exit 0
